/* tb.f */
logic/gb_cart_pkg.sv
logic/cart_header_capture.sv
logic/mbc_registers.sv
logic/bank_mapper.sv
logic/request_issue.sv
logic/cart_mapper_top.sv
tests/cart_mapper_properties.sv
tests/cart_mapper_checker.sv
tests/tb_cart_mapper.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cartridge mapper testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_cart_mapper -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -q "Simulation passed"; then
	exit 0
fi
exit 1

/* tests/tb_cart_mapper.sv */
// testbench top for the cartridge mapper
// clock, reset, stimulus table, timeout and closing report
`timescale 1ns/1ns
`default_nettype none

module tb_cart_mapper import gb_cart_pkg::*;;

	localparam int TABLE_MAX = 64;
	localparam int CYCLES_PER_ROW = 20;
	localparam int HOLD_CYCLES = 30;   // credit stall for the burst

	logic                  clk_sys = 1'b0;
	logic                  reset;
	logic                  dl_active, dl_wr;
	logic [DL_ADDR_W-1:0]  dl_addr;
	logic [DL_DATA_W-1:0]  dl_data;
	logic                  cpu_valid, cpu_wr, cpu_ready;
	logic [CPU_ADDR_W-1:0] cpu_addr;
	logic [CPU_DATA_W-1:0] cpu_data;
	logic                  mem_valid, mem_is_cram, mem_wr, mem_credit;
	logic [ROM_ADDR_W-1:0] mem_addr;
	logic [CPU_DATA_W-1:0] mem_data;

	// stimulus table, op 0 header, 1 cpu access, 2 credit hold
	logic [1:0]            t_op       [TABLE_MAX];
	logic                  t_wr       [TABLE_MAX];
	logic [15:0]           t_addr     [TABLE_MAX];
	logic [7:0]            t_data     [TABLE_MAX];   // type code on header rows
	logic [15:0]           t_aux      [TABLE_MAX];   // {ram code, rom code}
	logic [1:0]            t_exp      [TABLE_MAX];   // 0 none, 1 rom, 2 ram
	logic [22:0]           t_exp_addr [TABLE_MAX];
	int                    n_rows = 0;

	int   cycle_cnt = 0;
	int   timeout_limit = TABLE_MAX * CYCLES_PER_ROW;
	int   tb_errors = 0;
	logic saw_stall = 1'b0;            // ready seen low

	always #2 clk_sys = ~clk_sys;

	cart_mapper_top #(.MEM_CREDITS(4), .BUF_DEPTH(4)) dut0 (
		.clk_sys (clk_sys), .reset (reset),
		.dl_active_i (dl_active), .dl_wr_i (dl_wr), .dl_addr_i (dl_addr), .dl_data_i (dl_data),
		.cpu_valid_i (cpu_valid), .cpu_wr_i (cpu_wr), .cpu_addr_i (cpu_addr),
		.cpu_data_i (cpu_data), .cpu_ready_o (cpu_ready),
		.mem_valid_o (mem_valid), .mem_is_cram_o (mem_is_cram), .mem_wr_o (mem_wr),
		.mem_addr_o (mem_addr), .mem_data_o (mem_data), .mem_credit_i (mem_credit)
	);

	cart_mapper_checker checker0 (
		.clk_sys (clk_sys), .reset (reset),
		.mem_valid_i (mem_valid), .mem_is_cram_i (mem_is_cram), .mem_wr_i (mem_wr),
		.mem_addr_i (mem_addr), .mem_data_i (mem_data), .mem_credit_o (mem_credit)
	);

	task automatic add_row(input logic [1:0] op, input logic wr, input logic [15:0] addr,
	                       input logic [7:0] data, input logic [15:0] aux,
	                       input logic [1:0] exp, input logic [22:0] exp_addr);
		t_op[n_rows] = op;
		t_wr[n_rows] = wr;
		t_addr[n_rows] = addr;
		t_data[n_rows] = data;
		t_aux[n_rows] = aux;
		t_exp[n_rows] = exp;
		t_exp_addr[n_rows] = exp_addr;
		n_rows++;
	endtask

	task automatic header_row(input logic [7:0] type_code, input logic [15:0] sizes);
		add_row(2'd0, 1'b0, 16'h0000, type_code, sizes, 2'd0, 23'h0);
	endtask

	task automatic cpu_row(input logic wr, input logic [15:0] addr, input logic [7:0] data,
	                       input logic [1:0] exp, input logic [22:0] exp_addr);
		add_row(2'd1, wr, addr, data, 16'h0000, exp, exp_addr);
	endtask

	// two header words while the download is active
	task automatic send_header(input logic [7:0] type_code, input logic [15:0] sizes);
		dl_active = 1'b1;
		dl_wr     = 1'b1;
		dl_addr   = HDR_TYPE_ADDR;
		dl_data   = {type_code, 8'h00};
		@(posedge clk_sys);
		#1;
		dl_addr = HDR_SIZE_ADDR;
		dl_data = sizes;
		@(posedge clk_sys);
		#1;
		dl_wr     = 1'b0;
		dl_active = 1'b0;
	endtask

	// hold valid until an edge with ready, then queue the expected request
	task automatic send_access(input int r);
		logic accepted;
		accepted  = 1'b0;
		cpu_valid = 1'b1;
		cpu_wr    = t_wr[r];
		cpu_addr  = t_addr[r];
		cpu_data  = t_data[r];
		while (!accepted) begin
			@(negedge clk_sys);
			if (cpu_ready)
				accepted = 1'b1;
			else
				saw_stall = 1'b1;
			@(posedge clk_sys);
		end
		if (t_exp[r] != 2'd0)
			checker0.push_expected(t_exp[r] == 2'd2, t_wr[r], t_exp_addr[r], t_data[r]);
		#1;
		cpu_valid = 1'b0;
	endtask

	task automatic build_table();
		int i;
		// mbc1, rom mask 7, ram mask 3
		header_row(8'h01, 16'h0302);
		cpu_row(1'b1, 16'h2000, 8'h1D, 2'd0, 23'h0);
		cpu_row(1'b0, 16'h4123, 8'h00, 2'd1, 23'h14123);   // 0x1d and 7 is bank 5
		cpu_row(1'b0, 16'h0100, 8'h00, 2'd1, 23'h00100);
		cpu_row(1'b1, 16'h2000, 8'h00, 2'd0, 23'h0);        // bank 0 turns into 1
		cpu_row(1'b0, 16'h7FFF, 8'h00, 2'd1, 23'h07FFF);
		// mbc1 modes with a 128 bank rom
		header_row(8'h03, 16'h0306);
		cpu_row(1'b1, 16'h0000, 8'h0A, 2'd0, 23'h0);
		cpu_row(1'b1, 16'h2000, 8'h05, 2'd0, 23'h0);
		cpu_row(1'b1, 16'h4000, 8'h02, 2'd0, 23'h0);
		cpu_row(1'b0, 16'h4000, 8'h00, 2'd1, 23'h114000);  // mode 0, bank 0x45
		cpu_row(1'b1, 16'hA000, 8'h11, 2'd2, 23'h00000);   // ram bank 0
		cpu_row(1'b1, 16'h6000, 8'h01, 2'd0, 23'h0);
		cpu_row(1'b0, 16'h4000, 8'h00, 2'd1, 23'h014000);
		cpu_row(1'b0, 16'hA123, 8'h00, 2'd2, 23'h04123);   // mode 1, ram bank 2
		// mbc3, rom mask 63, ram mask 3
		header_row(8'h13, 16'h0305);
		cpu_row(1'b1, 16'hA000, 8'h55, 2'd0, 23'h0);       // ram still closed
		cpu_row(1'b1, 16'h0000, 8'h0A, 2'd0, 23'h0);
		cpu_row(1'b1, 16'h4000, 8'h02, 2'd0, 23'h0);
		cpu_row(1'b1, 16'hA010, 8'h5A, 2'd2, 23'h04010);
		cpu_row(1'b0, 16'hBFFF, 8'h00, 2'd2, 23'h05FFF);
		cpu_row(1'b1, 16'h2000, 8'h45, 2'd0, 23'h0);
		cpu_row(1'b0, 16'h5555, 8'h00, 2'd1, 23'h15555);
		cpu_row(1'b1, 16'h4000, 8'h08, 2'd0, 23'h0);       // rtc selected
		cpu_row(1'b0, 16'hA010, 8'h00, 2'd0, 23'h0);
		cpu_row(1'b1, 16'hA010, 8'h77, 2'd0, 23'h0);
		// mbc5, nine bit rom bank, ram mask 15
		header_row(8'h19, 16'h0408);
		cpu_row(1'b1, 16'h2000, 8'h34, 2'd0, 23'h0);
		cpu_row(1'b1, 16'h3000, 8'h01, 2'd0, 23'h0);
		cpu_row(1'b0, 16'h7FFF, 8'h00, 2'd1, 23'h4D3FFF);
		cpu_row(1'b1, 16'h2000, 8'h00, 2'd0, 23'h0);
		cpu_row(1'b1, 16'h3000, 8'h00, 2'd0, 23'h0);
		cpu_row(1'b0, 16'h4001, 8'h00, 2'd1, 23'h00001);   // bank 0 stays 0
		cpu_row(1'b1, 16'h0000, 8'h0A, 2'd0, 23'h0);
		cpu_row(1'b1, 16'h4000, 8'h0D, 2'd0, 23'h0);
		cpu_row(1'b0, 16'hA7FF, 8'h00, 2'd2, 23'h1A7FF);
		cpu_row(1'b1, 16'h2000, 8'h21, 2'd0, 23'h0);
		// burst of rom reads with no credits coming back
		add_row(2'd2, 1'b0, 16'h0000, 8'h00, 16'h0000, 2'd0, 23'h0);
		for (i = 1; i <= 10; i++)
			cpu_row(1'b0, 16'h4000 + 16'(i * 16), 8'h00, 2'd1, 23'h84000 + 23'(i * 16));
		// plain rom cartridge
		header_row(8'h00, 16'h0000);
		cpu_row(1'b0, 16'h5000, 8'h00, 2'd1, 23'h05000);
		cpu_row(1'b1, 16'h2000, 8'h03, 2'd0, 23'h0);
		cpu_row(1'b0, 16'h6000, 8'h00, 2'd1, 23'h06000);
		cpu_row(1'b0, 16'h1234, 8'h00, 2'd1, 23'h01234);
		cpu_row(1'b1, 16'hC000, 8'h99, 2'd0, 23'h0);       // outside the cart window
	endtask

	// run limit
	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_limit) begin
			$display("timeout after %0d cycles, requests still pending", cycle_cnt);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int r;
		int total;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		cpu_valid = 1'b0;
		cpu_wr    = 1'b0;
		cpu_addr  = '0;
		cpu_data  = '0;
		build_table();
		timeout_limit = n_rows * CYCLES_PER_ROW;
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		for (r = 0; r < n_rows; r++) begin
			case (t_op[r])
				2'd0: send_header(t_data[r], t_aux[r]);
				2'd1: send_access(r);
				default: checker0.withhold_credits(HOLD_CYCLES);
			endcase
		end
		// drain, then watch a while for stray requests
		while (checker0.pending() != 0)
			@(posedge clk_sys);
		repeat (20) @(posedge clk_sys);
		if (!saw_stall) begin
			$display("cpu_ready_o never dropped during the credit stall");
			tb_errors++;
		end
		total = tb_errors + checker0.err_cnt;
		$display("errors: %0d (checker %0d, testbench %0d)", total, checker0.err_cnt, tb_errors);
		if (total == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/cart_mapper_checker.sv */
// memory port monitor with in-order request comparison
// credit return with lcg delays and a credit hold
`timescale 1ns/1ns
`default_nettype none

module cart_mapper_checker (
	input  wire logic        clk_sys,
	input  wire logic        reset,
	input  wire logic        mem_valid_i,
	input  wire logic        mem_is_cram_i,
	input  wire logic        mem_wr_i,
	input  wire logic [22:0] mem_addr_i,
	input  wire logic [7:0]  mem_data_i,
	output logic             mem_credit_o
);

	logic [32:0] exp_q [$];     // {cram, wr, addr, data}
	int          err_cnt = 0;
	int          owed;          // credits to give back
	int          hold_cnt;
	int          wait_cnt;
	logic [31:0] lcg;
	logic        credit_q;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic push_expected(input logic cram, input logic wr, input logic [22:0] addr,
	                             input logic [7:0] data);
		exp_q.push_back({cram, wr, addr, data});
	endtask

	task automatic withhold_credits(input int cycles);
		hold_cnt = cycles;
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic compare_request();
		logic [32:0] e;
		if (exp_q.size() == 0) begin
			$display("at %0t a request to %h arrived with none expected", $time, mem_addr_i);
			err_cnt++;
			return;
		end
		e = exp_q.pop_front();
		if (mem_is_cram_i !== e[32]) begin
			$display("mismatch at %0t: mem_is_cram_o expected %b got %b", $time, e[32], mem_is_cram_i);
			err_cnt++;
		end
		if (mem_wr_i !== e[31]) begin
			$display("mismatch at %0t: mem_wr_o expected %b got %b", $time, e[31], mem_wr_i);
			err_cnt++;
		end
		if (mem_addr_i !== e[30:8]) begin
			$display("mismatch at %0t: mem_addr_o expected %h got %h", $time, e[30:8], mem_addr_i);
			err_cnt++;
		end
		if (mem_data_i !== e[7:0]) begin
			$display("mismatch at %0t: mem_data_o expected %h got %h", $time, e[7:0], mem_data_i);
			err_cnt++;
		end
	endtask

	always @(posedge clk_sys) begin
		if (reset) begin
			owed     = 0;
			hold_cnt = 0;
			wait_cnt = 0;
			lcg      = 32'h4743;
			credit_q <= 1'b0;
		end else begin
			credit_q <= 1'b0;
			if (hold_cnt > 0)
				hold_cnt--;                   // memory stalled
			else if (owed > 0) begin
				if (wait_cnt > 0)
					wait_cnt--;
				else begin
					credit_q <= 1'b1;
					owed--;
					lcg = lcg_next(lcg);
					wait_cnt = int'(lcg[17:16]);  // 0..3 idle cycles before the next
				end
			end
			if (mem_valid_i) begin
				owed++;
				compare_request();
			end
		end
	end

	// credit pulse driven just after the edge
	initial begin
		mem_credit_o = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			mem_credit_o = credit_q;
		end
	end

endmodule

`default_nettype wire

/* tests/cart_mapper_properties.sv */
// concurrent assertions on the credit port and cpu ready
// bound into request_issue
`timescale 1ns/1ns
`default_nettype none

module cart_mapper_properties #(
	parameter int MEM_CREDITS = 4,
	parameter int CRD_W       = 3
) (
	input wire logic             clk_sys,
	input wire logic             reset,
	input wire logic             mem_valid_i,
	input wire logic             mem_credit_i,
	input wire logic [CRD_W-1:0] credit_cnt_i,
	input wire logic             cpu_ready_i
);

	logic [CRD_W-1:0] port_credits;  // credits as counted on the memory port

	// one credit back per pulse, one spent per request
	always_ff @(posedge clk_sys) begin
		if (reset)
			port_credits <= CRD_W'(MEM_CREDITS);
		else
			port_credits <= port_credits + CRD_W'(mem_credit_i) - CRD_W'(mem_valid_i);
	end

	// a request always spends an existing credit
	no_request_without_credit: assert property (@(posedge clk_sys) disable iff (reset)
		mem_valid_i |-> (port_credits != '0))
		else $error("request issued with no credit left");

	credit_bounded: assert property (@(posedge clk_sys) disable iff (reset)
		credit_cnt_i <= CRD_W'(MEM_CREDITS))
		else $error("credit count above its initial value");

	ready_after_reset: assert property (@(posedge clk_sys) $fell(reset) |-> cpu_ready_i)
		else $error("cpu ready low after reset");

endmodule

bind request_issue cart_mapper_properties #(
	.MEM_CREDITS (MEM_CREDITS),
	.CRD_W       (CRD_W)
) props0 (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.mem_valid_i  (mem_valid_o),
	.mem_credit_i (mem_credit_i),
	.credit_cnt_i (credit_cnt),
	.cpu_ready_i  (cpu_ready_o)
);

`default_nettype wire

/* logic/cart_mapper_top.sv */
// cartridge mapper top level
// header capture, register stage, bank mapping and request issue
`timescale 1ns/1ns
`default_nettype none

module cart_mapper_top import gb_cart_pkg::*; #(
	parameter int MEM_CREDITS = 4,   // initial memory credits
	parameter int BUF_DEPTH   = 4    // request fifo depth
) (
	input  wire logic                  clk_sys,
	input  wire logic                  reset,
	input  wire logic                  dl_active_i,
	input  wire logic                  dl_wr_i,
	input  wire logic [DL_ADDR_W-1:0]  dl_addr_i,
	input  wire logic [DL_DATA_W-1:0]  dl_data_i,
	input  wire logic                  cpu_valid_i,
	input  wire logic                  cpu_wr_i,
	input  wire logic [CPU_ADDR_W-1:0] cpu_addr_i,
	input  wire logic [CPU_DATA_W-1:0] cpu_data_i,
	output logic                       cpu_ready_o,
	output logic                       mem_valid_o,
	output logic                       mem_is_cram_o,
	output logic                       mem_wr_o,
	output logic [ROM_ADDR_W-1:0]      mem_addr_o,
	output logic [CPU_DATA_W-1:0]      mem_data_o,
	input  wire logic                  mem_credit_i
);

	mapper_kind_e            mapper;
	rom_bank_t               rom_mask;
	ram_bank_t               ram_mask;

	// stage 1 to stage 2
	logic                    s1_valid, s1_wr, s1_mbc1_mode, s1_rtc_sel, s1_ram_en;
	logic [CPU_ADDR_W-1:0]   s1_addr;
	logic [CPU_DATA_W-1:0]   s1_data;
	mapper_kind_e            s1_mapper;
	rom_bank_t               s1_rom_bank, s1_rom_mask;
	ram_bank_t               s1_ram_bank, s1_ram_mask;

	// stage 2 to issue
	logic                    map_valid, map_keep, map_is_cram, map_wr;
	logic [ROM_ADDR_W-1:0]   map_addr;
	logic [CPU_DATA_W-1:0]   map_data;

	cart_header_capture hdr0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_wr_i    (dl_wr_i),
		.dl_addr_i  (dl_addr_i),
		.dl_data_i  (dl_data_i),
		.mapper_o   (mapper),
		.rom_mask_o (rom_mask),
		.ram_mask_o (ram_mask)
	);

	mbc_registers regs0 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.dl_active_i    (dl_active_i),
		.cpu_valid_i    (cpu_valid_i),
		.cpu_ready_i    (cpu_ready_o),
		.cpu_wr_i       (cpu_wr_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_data_i     (cpu_data_i),
		.mapper_i       (mapper),
		.rom_mask_i     (rom_mask),
		.ram_mask_i     (ram_mask),
		.s1_valid_o     (s1_valid),
		.s1_wr_o        (s1_wr),
		.s1_addr_o      (s1_addr),
		.s1_data_o      (s1_data),
		.s1_mapper_o    (s1_mapper),
		.s1_rom_bank_o  (s1_rom_bank),
		.s1_ram_bank_o  (s1_ram_bank),
		.s1_mbc1_mode_o (s1_mbc1_mode),
		.s1_rtc_sel_o   (s1_rtc_sel),
		.s1_ram_en_o    (s1_ram_en),
		.s1_rom_mask_o  (s1_rom_mask),
		.s1_ram_mask_o  (s1_ram_mask)
	);

	bank_mapper map0 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.s1_valid_i     (s1_valid),
		.s1_wr_i        (s1_wr),
		.s1_addr_i      (s1_addr),
		.s1_data_i      (s1_data),
		.s1_mapper_i    (s1_mapper),
		.s1_rom_bank_i  (s1_rom_bank),
		.s1_ram_bank_i  (s1_ram_bank),
		.s1_mbc1_mode_i (s1_mbc1_mode),
		.s1_rtc_sel_i   (s1_rtc_sel),
		.s1_ram_en_i    (s1_ram_en),
		.s1_rom_mask_i  (s1_rom_mask),
		.s1_ram_mask_i  (s1_ram_mask),
		.map_valid_o    (map_valid),
		.map_keep_o     (map_keep),
		.map_is_cram_o  (map_is_cram),
		.map_wr_o       (map_wr),
		.map_addr_o     (map_addr),
		.map_data_o     (map_data)
	);

	request_issue #(
		.MEM_CREDITS (MEM_CREDITS),
		.BUF_DEPTH   (BUF_DEPTH)
	) issue0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cpu_valid_i   (cpu_valid_i),
		.map_valid_i   (map_valid),
		.map_keep_i    (map_keep),
		.map_is_cram_i (map_is_cram),
		.map_wr_i      (map_wr),
		.map_addr_i    (map_addr),
		.map_data_i    (map_data),
		.mem_credit_i  (mem_credit_i),
		.cpu_ready_o   (cpu_ready_o),
		.mem_valid_o   (mem_valid_o),
		.mem_is_cram_o (mem_is_cram_o),
		.mem_wr_o      (mem_wr_o),
		.mem_addr_o    (mem_addr_o),
		.mem_data_o    (mem_data_o)
	);

endmodule

`default_nettype wire

/* logic/request_issue.sv */
// stage 3 of the cartridge pipeline
// request fifo, in-flight reservation, memory credits and cpu ready
`timescale 1ns/1ns
`default_nettype none

module request_issue import gb_cart_pkg::*; #(
	parameter int MEM_CREDITS = 4,
	parameter int BUF_DEPTH   = 4
) (
	input  wire logic                  clk_sys,
	input  wire logic                  reset,
	input  wire logic                  cpu_valid_i,
	input  wire logic                  map_valid_i,
	input  wire logic                  map_keep_i,
	input  wire logic                  map_is_cram_i,
	input  wire logic                  map_wr_i,
	input  wire logic [ROM_ADDR_W-1:0] map_addr_i,
	input  wire logic [CPU_DATA_W-1:0] map_data_i,
	input  wire logic                  mem_credit_i,
	output logic                       cpu_ready_o,
	output logic                       mem_valid_o,
	output logic                       mem_is_cram_o,
	output logic                       mem_wr_o,
	output logic [ROM_ADDR_W-1:0]      mem_addr_o,
	output logic [CPU_DATA_W-1:0]      mem_data_o
);

	localparam int PTR_W   = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CNT_W   = $clog2(BUF_DEPTH + 1);
	localparam int CRD_W   = $clog2(MEM_CREDITS + 1);
	localparam int ENTRY_W = 2 + ROM_ADDR_W + CPU_DATA_W;  // cram, wr, addr, data

	logic [ENTRY_W-1:0] req_mem [BUF_DEPTH];
	logic [PTR_W-1:0]   wr_ptr, rd_ptr;
	logic [CNT_W-1:0]   fill_cnt;        // requests held in the fifo
	logic [CNT_W-1:0]   inflight_cnt;    // accepted, not yet out of stage 2
	logic [CRD_W-1:0]   credit_cnt;
	logic [CNT_W:0]     occupancy;
	logic               cpu_acc, push, pop;

	//----------------------------------------------------------------------
	// cpu side reservation
	//----------------------------------------------------------------------
	assign occupancy   = {1'b0, fill_cnt} + {1'b0, inflight_cnt};
	assign cpu_ready_o = (occupancy < (CNT_W + 1)'(BUF_DEPTH));  // fifo cannot overflow
	assign cpu_acc     = cpu_valid_i & cpu_ready_o;

	assign push = map_valid_i & map_keep_i;            // dropped accesses only release
	assign pop  = (fill_cnt != '0) && (credit_cnt != '0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			inflight_cnt <= '0;
			fill_cnt     <= '0;
			credit_cnt   <= CRD_W'(MEM_CREDITS);
			wr_ptr       <= '0;
			rd_ptr       <= '0;
		end else begin
			inflight_cnt <= inflight_cnt + CNT_W'(cpu_acc) - CNT_W'(map_valid_i);
			fill_cnt     <= fill_cnt + CNT_W'(push) - CNT_W'(pop);
			credit_cnt   <= credit_cnt + CRD_W'(mem_credit_i) - CRD_W'(pop);
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	// fifo storage
	always_ff @(posedge clk_sys) begin
		if (push)
			req_mem[wr_ptr] <= {map_is_cram_i, map_wr_i, map_addr_i, map_data_i};
	end

	//----------------------------------------------------------------------
	// memory port, head shown for one cycle per credit spent
	//----------------------------------------------------------------------
	assign mem_valid_o = pop;
	assign {mem_is_cram_o, mem_wr_o, mem_addr_o, mem_data_o} = req_mem[rd_ptr];

endmodule

`default_nettype wire

/* logic/bank_mapper.sv */
// stage 2 of the cartridge pipeline
// rom and cart ram address translation, drop of non-memory accesses
`timescale 1ns/1ns
`default_nettype none

module bank_mapper import gb_cart_pkg::*; (
	input  wire logic                  clk_sys,
	input  wire logic                  reset,
	input  wire logic                  s1_valid_i,
	input  wire logic                  s1_wr_i,
	input  wire logic [CPU_ADDR_W-1:0] s1_addr_i,
	input  wire logic [CPU_DATA_W-1:0] s1_data_i,
	input  mapper_kind_e               s1_mapper_i,
	input  rom_bank_t                  s1_rom_bank_i,
	input  ram_bank_t                  s1_ram_bank_i,
	input  wire logic                  s1_mbc1_mode_i,
	input  wire logic                  s1_rtc_sel_i,
	input  wire logic                  s1_ram_en_i,
	input  rom_bank_t                  s1_rom_mask_i,
	input  ram_bank_t                  s1_ram_mask_i,
	output logic                       map_valid_o,
	output logic                       map_keep_o,
	output logic                       map_is_cram_o,
	output logic                       map_wr_o,
	output logic [ROM_ADDR_W-1:0]      map_addr_o,
	output logic [CPU_DATA_W-1:0]      map_data_o
);

	logic      is_rom_rd;   // read in 0000-7fff
	logic      is_cram;     // a000-bfff window
	logic      keep;
	rom_bank_t rom_hi;      // bank seen in 4000-7fff
	rom_bank_t rom_sel;
	ram_bank_t ram_sel;

	assign is_rom_rd = ~s1_addr_i[15] & ~s1_wr_i;
	assign is_cram   = (s1_addr_i[15:13] == 3'b101);

	//----------------------------------------------------------------------
	// bank selection per mapper
	//----------------------------------------------------------------------
	always_comb begin
		case (s1_mapper_i)
			MAPPER_MBC1: begin
				// mode 0 puts the ram bank bits on the upper rom lines
				rom_hi  = {2'b00, (s1_mbc1_mode_i ? 2'b00 : s1_ram_bank_i[1:0]),
				           s1_rom_bank_i[4:0]} & s1_rom_mask_i;
				ram_sel = {2'b00, (s1_mbc1_mode_i ? s1_ram_bank_i[1:0] : 2'b00)}
				          & s1_ram_mask_i;
			end
			MAPPER_MBC2: begin
				rom_hi  = {2'b00, s1_rom_bank_i[6:0]} & s1_rom_mask_i;
				ram_sel = '0;                                   // single 512x4 ram
			end
			MAPPER_MBC3: begin
				rom_hi  = {2'b00, s1_rom_bank_i[6:0]} & s1_rom_mask_i;
				ram_sel = {2'b00, s1_ram_bank_i[1:0]} & s1_ram_mask_i;
			end
			MAPPER_MBC5: begin
				rom_hi  = s1_rom_bank_i & s1_rom_mask_i;         // full 9 bits, bank 0 ok
				ram_sel = s1_ram_bank_i & s1_ram_mask_i;
			end
			default: begin
				rom_hi  = rom_bank_t'(1);                       // flat 32k image
				ram_sel = '0;
			end
		endcase
	end

	assign rom_sel = s1_addr_i[14] ? rom_hi : '0;          // 0000-3fff is bank 0

	// ram only when opened and not switched to the rtc
	assign keep = is_rom_rd | (is_cram & s1_ram_en_i & ~s1_rtc_sel_i);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			map_valid_o <= 1'b0;
			map_keep_o  <= 1'b0;
		end else begin
			map_valid_o <= s1_valid_i;                      // every access arrives once
			map_keep_o  <= s1_valid_i & keep;
		end
	end

	always_ff @(posedge clk_sys) begin
		map_is_cram_o <= is_cram;
		map_wr_o      <= s1_wr_i;
		map_data_o    <= s1_data_i;
		if (is_cram)
			map_addr_o <= ROM_ADDR_W'({ram_sel, s1_addr_i[12:0]});
		else
			map_addr_o <= {rom_sel, s1_addr_i[13:0]};
	end

endmodule

`default_nettype wire

/* logic/mbc_registers.sv */
// stage 1 of the cartridge pipeline
// bank register writes and access capture with the bank snapshot
`timescale 1ns/1ns
`default_nettype none

module mbc_registers import gb_cart_pkg::*; (
	input  wire logic                  clk_sys,
	input  wire logic                  reset,
	input  wire logic                  dl_active_i,
	input  wire logic                  cpu_valid_i,
	input  wire logic                  cpu_ready_i,
	input  wire logic                  cpu_wr_i,
	input  wire logic [CPU_ADDR_W-1:0] cpu_addr_i,
	input  wire logic [CPU_DATA_W-1:0] cpu_data_i,
	input  mapper_kind_e               mapper_i,
	input  rom_bank_t                  rom_mask_i,
	input  ram_bank_t                  ram_mask_i,
	output logic                       s1_valid_o,
	output logic                       s1_wr_o,
	output logic [CPU_ADDR_W-1:0]      s1_addr_o,
	output logic [CPU_DATA_W-1:0]      s1_data_o,
	output mapper_kind_e               s1_mapper_o,
	output rom_bank_t                  s1_rom_bank_o,
	output ram_bank_t                  s1_ram_bank_o,
	output logic                       s1_mbc1_mode_o,
	output logic                       s1_rtc_sel_o,
	output logic                       s1_ram_en_o,
	output rom_bank_t                  s1_rom_mask_o,
	output ram_bank_t                  s1_ram_mask_o
);

	logic      cpu_acc;                  // transfer this cycle
	logic      reg_wr;                   // accepted write into 0000-7fff
	rom_bank_t rom_bank_q, rom_bank_n;
	ram_bank_t ram_bank_q, ram_bank_n;
	logic      mode_q, mode_n;           // mbc1 banking mode
	logic      rtc_q, rtc_n;             // mbc3 rtc select
	logic      ram_en_q, ram_en_n;

	assign cpu_acc = cpu_valid_i & cpu_ready_i;
	assign reg_wr  = cpu_acc & cpu_wr_i & ~cpu_addr_i[15];

	//----------------------------------------------------------------------
	// register write decode
	//----------------------------------------------------------------------
	always_comb begin
		rom_bank_n = rom_bank_q;
		ram_bank_n = ram_bank_q;
		mode_n     = mode_q;
		rtc_n      = rtc_q;
		ram_en_n   = ram_en_q;
		if (reg_wr) begin
			case (cpu_addr_i[14:13])
				2'b00: ram_en_n = (cpu_data_i[3:0] == RAM_ENABLE_KEY);
				2'b01: begin
					if (mapper_i == MAPPER_MBC5) begin
						if (cpu_addr_i[12])
							rom_bank_n[8] = cpu_data_i[0];    // 3xxx high bit
						else
							rom_bank_n[7:0] = cpu_data_i;     // 2xxx low byte
					end else if (cpu_data_i[6:0] == 7'd0) begin
						rom_bank_n = rom_bank_t'(1);          // bank 0 reads as 1
					end else begin
						rom_bank_n = {2'b00, cpu_data_i[6:0]};
					end
				end
				2'b10: begin
					if (mapper_i == MAPPER_MBC3) begin
						rtc_n = cpu_data_i[3];
						if (!cpu_data_i[3])
							ram_bank_n = {2'b00, cpu_data_i[1:0]};
					end else if (mapper_i == MAPPER_MBC5) begin
						ram_bank_n = cpu_data_i[3:0];
					end else begin
						ram_bank_n = {2'b00, cpu_data_i[1:0]};
					end
				end
				default: begin
					if (mapper_i == MAPPER_MBC1)
						mode_n = cpu_data_i[0];
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset || dl_active_i) begin       // new image resets the mapper
			rom_bank_q <= rom_bank_t'(1);
			ram_bank_q <= '0;
			mode_q     <= 1'b0;
			rtc_q      <= 1'b0;
			ram_en_q   <= 1'b0;
		end else begin
			rom_bank_q <= rom_bank_n;
			ram_bank_q <= ram_bank_n;
			mode_q     <= mode_n;
			rtc_q      <= rtc_n;
			ram_en_q   <= ram_en_n;
		end
	end

	// stage 1 output, valid is the only control bit
	always_ff @(posedge clk_sys) begin
		if (reset)
			s1_valid_o <= 1'b0;
		else
			s1_valid_o <= cpu_acc;
	end

	// snapshot holds the state after this access's own write
	always_ff @(posedge clk_sys) begin
		if (cpu_acc) begin
			s1_wr_o        <= cpu_wr_i;
			s1_addr_o      <= cpu_addr_i;
			s1_data_o      <= cpu_data_i;
			s1_mapper_o    <= mapper_i;
			s1_rom_bank_o  <= rom_bank_n;
			s1_ram_bank_o  <= ram_bank_n;
			s1_mbc1_mode_o <= mode_n;
			s1_rtc_sel_o   <= rtc_n;
			s1_ram_en_o    <= ram_en_n;
			s1_rom_mask_o  <= rom_mask_i;
			s1_ram_mask_o  <= ram_mask_i;
		end
	end

endmodule

`default_nettype wire

/* logic/cart_header_capture.sv */
// header byte capture during rom download
// mapper kind, rom mask and ram mask decoding
`timescale 1ns/1ns
`default_nettype none

module cart_header_capture import gb_cart_pkg::*; (
	input  wire logic                 clk_sys,
	input  wire logic                 reset,
	input  wire logic                 dl_wr_i,
	input  wire logic [DL_ADDR_W-1:0] dl_addr_i,
	input  wire logic [DL_DATA_W-1:0] dl_data_i,
	output mapper_kind_e              mapper_o,
	output rom_bank_t                 rom_mask_o,
	output ram_bank_t                 ram_mask_o
);

	logic [7:0] type_code;  // cartridge type byte
	logic [7:0] rom_code;   // rom size byte
	logic [7:0] ram_code;   // ram size byte

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_code <= 8'h00;
			rom_code  <= 8'h00;
			ram_code  <= 8'h00;
		end else if (dl_wr_i) begin
			if (dl_addr_i == HDR_TYPE_ADDR)
				type_code <= dl_data_i[15:8];
			if (dl_addr_i == HDR_SIZE_ADDR) begin
				rom_code <= dl_data_i[7:0];
				ram_code <= dl_data_i[15:8];
			end
		end
	end

	// type code ranges per mapper family
	always_comb begin
		if (type_code >= 8'd1 && type_code <= 8'd3)
			mapper_o = MAPPER_MBC1;
		else if (type_code >= 8'd5 && type_code <= 8'd6)
			mapper_o = MAPPER_MBC2;
		else if (type_code >= 8'd15 && type_code <= 8'd19)
			mapper_o = MAPPER_MBC3;
		else if (type_code >= 8'd25 && type_code <= 8'd30)
			mapper_o = MAPPER_MBC5;
		else
			mapper_o = MAPPER_NONE;  // plain rom or unsupported
	end

	// 2^(n+1) banks for codes 0..8, odd sizes fold to 128 banks
	assign rom_mask_o = (rom_code <= 8'd8) ? rom_bank_t'((10'd2 << rom_code[3:0]) - 10'd1)
	                                       : rom_bank_t'(127);

	assign ram_mask_o = (ram_code <= 8'd2) ? 4'h0 :   // none, 2k or 8k
	                    (ram_code == 8'd3) ? 4'h3 :   // 32k, 4 banks
	                                         4'hF;    // 128k, 16 banks

endmodule

`default_nettype wire

/* logic/gb_cart_pkg.sv */
// cartridge widths and header offsets
// mapper kinds and bank number types
`default_nettype none

package gb_cart_pkg;

	//----------------------------------------------------------------------
	// bus widths
	//----------------------------------------------------------------------
	localparam int CPU_ADDR_W  = 16;  // cpu cartridge window
	localparam int CPU_DATA_W  = 8;
	localparam int DL_ADDR_W   = 25;  // download byte address
	localparam int DL_DATA_W   = 16;  // download word
	localparam int ROM_ADDR_W  = 23;  // 512 banks of 16k
	localparam int CRAM_ADDR_W = 17;  // 16 banks of 8k

	//----------------------------------------------------------------------
	// header offsets in the rom image
	//----------------------------------------------------------------------
	// type code sits in the upper byte of this word
	localparam logic [DL_ADDR_W-1:0] HDR_TYPE_ADDR = DL_ADDR_W'('h146);
	// rom size in lower byte, ram size in upper byte
	localparam logic [DL_ADDR_W-1:0] HDR_SIZE_ADDR = DL_ADDR_W'('h148);

	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;  // low nibble opens cart ram

	// mapper kinds decoded from the type code
	typedef enum logic [2:0] {
		MAPPER_NONE = 3'd0,
		MAPPER_MBC1 = 3'd1,
		MAPPER_MBC2 = 3'd2,
		MAPPER_MBC3 = 3'd3,
		MAPPER_MBC5 = 3'd4
	} mapper_kind_e;

	typedef logic [8:0] rom_bank_t;  // 16k rom bank number
	typedef logic [3:0] ram_bank_t;  // 8k ram bank number

endpackage

`default_nettype wire
